// ==== source/conv_pad_config.svh ====
`ifndef CONV_PAD_CONFIG_SVH
`define CONV_PAD_CONFIG_SVH

// pixel width in bits
`define CONV_PAD_DATA_WIDTH 16

// widest kernel, odd
`define CONV_PAD_KERNEL_W_MAX 7

// column tag width
`define CONV_PAD_USER_WIDTH 4

`endif

// ==== source/conv_pad_pkg.sv ====
`default_nettype none

`include "conv_pad_config.svh"

package conv_pad_pkg;

    typedef logic [`CONV_PAD_DATA_WIDTH-1:0] pixel_t;

    // kernel width minus one
    typedef logic [$clog2(`CONV_PAD_KERNEL_W_MAX + 1) - 1:0] kw_t;

    typedef logic [`CONV_PAD_USER_WIDTH-1:0] user_t;

    // bit k set when tap k is live
    typedef logic [`CONV_PAD_KERNEL_W_MAX-1:0] mask_t;

    typedef struct packed {
        pixel_t pixel;
        user_t  user;
        logic   pad;    // flush beat, no data
        logic   first;  // first column of a row
        logic   last;   // last real column of a row
    } col_beat_t;

    typedef struct packed {
        pixel_t [`CONV_PAD_KERNEL_W_MAX-1:0] pixels;
        mask_t                               mask;
        user_t                               user;  // tag of the centre column
        logic                                last;  // centred on the last column
    } win_beat_t;

endpackage

`default_nettype wire

// ==== source/beat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface beat_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;  // held while valid and not ready

    modport src (
        output valid,
        output payload,
        input  ready
    );

    modport dst (
        input  valid,
        input  payload,
        output ready
    );

endinterface

`default_nettype wire

// ==== source/row_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_pad_config.svh"

module row_intake (
    input  wire                  aclk,
    input  wire                  rst,
    input  wire                  start,
    input  wire conv_pad_pkg::kw_t    kernel_w_1,
    input  wire                  s_valid,
    input  wire conv_pad_pkg::pixel_t s_data,
    input  wire conv_pad_pkg::user_t  s_user,
    input  wire                  s_last,
    output logic                 s_ready,
    beat_if.src                  col_out,
    output conv_pad_pkg::kw_t    kw
);
    import conv_pad_pkg::*;

    logic enabled;     // set by the first start
    logic first_next;  // next accepted column opens a row
    kw_t  pad_cnt;     // flush beats still to issue
    logic can_load;
    logic s_xfer;
    logic pad_issue;
    logic busy;

    assign can_load  = !col_out.valid || col_out.ready;
    assign s_ready   = enabled && !start && (pad_cnt == '0) && can_load;
    assign s_xfer    = s_valid && s_ready;
    assign pad_issue = (pad_cnt != '0) && can_load;

    // a row counts as open until its flush beats have left the slice
    assign busy = !first_next || (pad_cnt != '0) || col_out.valid;

    always_ff @(posedge aclk) begin
        if (rst) begin
            enabled <= 1'b0;
            kw      <= '0;
        end else if (start) begin
            enabled <= 1'b1;
            kw      <= kernel_w_1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            first_next <= 1'b1;
            pad_cnt    <= '0;
        end else if (s_xfer) begin
            first_next <= s_last;
            if (s_last) begin
                pad_cnt <= kw >> 1;  // half flush beats
            end
        end else if (pad_issue) begin
            pad_cnt <= pad_cnt - 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            col_out.valid <= 1'b0;
        end else if (can_load) begin
            col_out.valid <= s_xfer || pad_issue;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_xfer) begin
            col_out.payload <= col_beat_t'{
                pixel: s_data,
                user:  s_user,
                pad:   1'b0,
                first: first_next,
                last:  s_last
            };
        end else if (pad_issue) begin
            col_out.payload <= col_beat_t'{
                pixel: '0,
                user:  '0,
                pad:   1'b1,
                first: 1'b0,
                last:  1'b0
            };
        end
    end

    // only odd kernel widths that fit the window
    assert property (@(posedge aclk) disable iff (rst)
        start |-> (!kernel_w_1[0] && (kernel_w_1 < kw_t'(`CONV_PAD_KERNEL_W_MAX))));

    // new setting only between rows, once the flush has drained
    assert property (@(posedge aclk) disable iff (rst)
        start |-> !busy);

endmodule

`default_nettype wire

// ==== source/pad_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_pad_config.svh"

module pad_filter (
    input  wire               aclk,
    input  wire               rst,
    input  wire conv_pad_pkg::kw_t kw,
    beat_if.dst               col_in,
    beat_if.src               win_out
);
    import conv_pad_pkg::*;

    localparam int KMAX = `CONV_PAD_KERNEL_W_MAX;

    // slot 0 holds the newest column
    pixel_t [KMAX-1:0] pix_q;
    pixel_t [KMAX-1:0] pix_d;
    mask_t             in_q;   // slot lies inside the row
    mask_t             in_d;
    user_t  [KMAX-1:0] user_q;
    user_t  [KMAX-1:0] user_d;
    logic   [KMAX-1:0] last_q;
    logic   [KMAX-1:0] last_d;

    col_beat_t beat;
    win_beat_t win_d;
    kw_t       half;
    kw_t       cnt;   // beats since first, saturates at half
    kw_t       idx;
    logic      xfer;
    logic      emit;

    assign beat         = col_in.payload;
    assign half         = kw >> 1;
    assign col_in.ready = !win_out.valid || win_out.ready;
    assign xfer         = col_in.valid && col_in.ready;
    assign idx          = beat.first ? '0 : cnt;
    assign emit         = idx >= half;  // leading half beats only fill the window

    always_comb begin
        pix_d[0]  = beat.pad ? '0 : beat.pixel;
        in_d[0]   = !beat.pad;
        user_d[0] = beat.user;
        last_d[0] = beat.last;
        for (int i = 1; i < KMAX; i++) begin
            pix_d[i]  = beat.first ? '0 : pix_q[i-1];  // older slots belong to the previous row
            in_d[i]   = beat.first ? 1'b0 : in_q[i-1];
            user_d[i] = beat.first ? '0 : user_q[i-1];
            last_d[i] = beat.first ? 1'b0 : last_q[i-1];
        end
    end

    // tap k maps to slot kw-k, the newest column sits on tap kw
    always_comb begin
        win_d = '0;
        for (int k = 0; k < KMAX; k++) begin
            if (k <= int'(kw)) begin
                win_d.pixels[k] = pix_d[int'(kw) - k];
                win_d.mask[k]   = in_d[int'(kw) - k];
            end
        end
        win_d.user = user_d[half];  // centre slot
        win_d.last = last_d[half];
    end

    always_ff @(posedge aclk) begin
        if (xfer) begin
            pix_q  <= pix_d;
            in_q   <= in_d;
            user_q <= user_d;
            last_q <= last_d;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            cnt <= '0;
        end else if (xfer) begin
            cnt <= emit ? idx : idx + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            win_out.valid <= 1'b0;
        end else if (col_in.ready) begin
            win_out.valid <= xfer && emit;
        end
    end

    always_ff @(posedge aclk) begin
        if (xfer && emit) begin
            win_out.payload <= win_d;
        end
    end

    // flush beats never open a row
    assert property (@(posedge aclk) disable iff (rst)
        (col_in.valid && col_in.payload.pad) |-> !col_in.payload.first);

endmodule

`default_nettype wire

// ==== source/window_emitter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_pad_config.svh"

module window_emitter (
    input  wire                 aclk,
    input  wire                 rst,
    input  wire                 m_ready,
    beat_if.dst                 win_in,
    output logic                m_valid,
    output conv_pad_pkg::pixel_t [`CONV_PAD_KERNEL_W_MAX-1:0] m_window,
    output conv_pad_pkg::mask_t m_mask,
    output conv_pad_pkg::user_t m_user,
    output logic                m_last
);
    import conv_pad_pkg::*;

    localparam int KMAX = `CONV_PAD_KERNEL_W_MAX;

    win_beat_t         beat;
    pixel_t [KMAX-1:0] taps;
    logic              xfer;

    assign beat         = win_in.payload;
    assign win_in.ready = !m_valid || m_ready;
    assign xfer         = win_in.valid && win_in.ready;

    always_comb begin
        for (int k = 0; k < KMAX; k++) begin
            taps[k] = beat.mask[k] ? beat.pixels[k] : '0;  // padded taps read as zero
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (win_in.ready) begin
            m_valid <= win_in.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (xfer) begin
            m_window <= taps;
            m_mask   <= beat.mask;
            m_user   <= beat.user;
            m_last   <= beat.last;
        end
    end

endmodule

`default_nettype wire

// ==== source/conv_pad_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_pad_config.svh"

module conv_pad_top (
    input  wire                  aclk,
    input  wire                  rst,
    input  wire                  start,
    input  wire conv_pad_pkg::kw_t    kernel_w_1,
    input  wire                  s_valid,
    input  wire conv_pad_pkg::pixel_t s_data,
    input  wire conv_pad_pkg::user_t  s_user,
    input  wire                  s_last,
    output logic                 s_ready,
    input  wire                  m_ready,
    output logic                 m_valid,
    output conv_pad_pkg::pixel_t [`CONV_PAD_KERNEL_W_MAX-1:0] m_window,
    output conv_pad_pkg::mask_t  m_mask,
    output conv_pad_pkg::user_t  m_user,
    output logic                 m_last
);
    import conv_pad_pkg::*;

    kw_t kw;  // latched kernel setting

    beat_if #(.payload_t(col_beat_t)) col_bus ();
    beat_if #(.payload_t(win_beat_t)) win_bus ();

    row_intake u_row_intake (
        .aclk       (aclk),
        .rst        (rst),
        .start      (start),
        .kernel_w_1 (kernel_w_1),
        .s_valid    (s_valid),
        .s_data     (s_data),
        .s_user     (s_user),
        .s_last     (s_last),
        .s_ready    (s_ready),
        .col_out    (col_bus),
        .kw         (kw)
    );

    pad_filter u_pad_filter (
        .aclk    (aclk),
        .rst     (rst),
        .kw      (kw),
        .col_in  (col_bus),
        .win_out (win_bus)
    );

    window_emitter u_window_emitter (
        .aclk     (aclk),
        .rst      (rst),
        .m_ready  (m_ready),
        .win_in   (win_bus),
        .m_valid  (m_valid),
        .m_window (m_window),
        .m_mask   (m_mask),
        .m_user   (m_user),
        .m_last   (m_last)
    );

endmodule

`default_nettype wire

// ==== dv/conv_pad_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_pad_config.svh"

module conv_pad_tb;
    import conv_pad_pkg::*;

    localparam int KMAX        = `CONV_PAD_KERNEL_W_MAX;
    localparam int MAX_W       = 12;
    localparam int NUM_ROWS    = 40;
    localparam int CYCLE_LIMIT = NUM_ROWS * 40;

    logic              aclk;
    logic              rst;
    logic              start;
    kw_t               kernel_w_1;
    logic              s_valid;
    pixel_t            s_data;
    user_t             s_user;
    logic              s_last;
    logic              s_ready;
    logic              m_ready;
    logic              m_valid;
    pixel_t [KMAX-1:0] m_window;
    mask_t             m_mask;
    user_t             m_user;
    logic              m_last;

    win_beat_t   exp_q[$];                 // windows still owed by the DUT
    pixel_t      row_pix [MAX_W];
    user_t       row_tag [MAX_W];
    logic [31:0] rng        = 32'd67667;
    logic [31:0] rdy_rng    = ~32'd67667;  // own stream for m_ready
    int          acc_cnt    = 0;
    int          rx_cnt     = 0;
    int          exp_total  = 0;
    int          bad_values = 0;
    int          bad_other  = 0;
    int          cycle_cnt  = 0;
    int          cur_half   = 0;
    int          gap_cnt    = 0;
    int          gap_half   = 0;
    logic        gap_active = 1'b0;
    logic        gap_strict = 1'b0;
    logic        started    = 1'b0;
    logic        stall_row  = 1'b0;
    logic        stall_now  = 1'b0;

    conv_pad_top dut_i (
        .aclk(aclk), .rst(rst), .start(start), .kernel_w_1(kernel_w_1),
        .s_valid(s_valid), .s_data(s_data), .s_user(s_user), .s_last(s_last),
        .s_ready(s_ready), .m_ready(m_ready), .m_valid(m_valid), .m_window(m_window),
        .m_mask(m_mask), .m_user(m_user), .m_last(m_last)
    );

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int pick(input int n);
        rng = lcg_step(rng);
        return int'(rng[31:16]) % n;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] want);
        bad_values++;
        $display("mismatch %s: got %h, expected %h", name, got, want);
    endtask

    task automatic note_failure(input string what);
        bad_other++;
        $display("error: %s", what);
    endtask

    // tap k of window c reads column c+k-half
    task automatic queue_windows(input int width, input int kw1);
        win_beat_t w;
        int        half;
        int        col;
        half = kw1 / 2;
        for (int c = 0; c < width; c++) begin
            w = '0;
            for (int k = 0; k <= kw1; k++) begin
                col = c + k - half;
                if (col >= 0 && col < width) begin
                    w.pixels[k] = row_pix[col];
                    w.mask[k]   = 1'b1;
                end
            end
            w.user = row_tag[c];
            w.last = (c == width - 1);
            exp_q.push_back(w);
            exp_total++;
        end
    endtask

    task automatic check_window();
        win_beat_t want;
        if (exp_q.size() == 0) begin
            note_failure("window arrived with no row pending");
        end else begin
            want = exp_q.pop_front();
            assert (m_window == want.pixels)
                else report_mismatch("m_window", 128'(m_window), 128'(want.pixels));
            assert (m_mask == want.mask)
                else report_mismatch("m_mask", 128'(m_mask), 128'(want.mask));
            assert (m_user == want.user)
                else report_mismatch("m_user", 128'(m_user), 128'(want.user));
            assert (m_last == want.last)
                else report_mismatch("m_last", 128'(m_last), 128'(want.last));
        end
        rx_cnt++;
    endtask

    task automatic run_row();
        int width;
        int kw1;
        int target;
        width = 1 + pick(MAX_W);
        kw1   = 2 * pick(4);  // kernel widths 1, 3, 5, 7
        for (int c = 0; c < width; c++) begin
            row_pix[c] = pixel_t'(pick(65536));
            row_tag[c] = user_t'(pick(16));
        end
        stall_row = (pick(2) == 0);
        cur_half  = kw1 / 2;
        queue_windows(width, kw1);
        kernel_w_1 = kw_t'(kw1);
        start      = 1'b1;
        @(posedge aclk);
        #1;
        start = 1'b0;
        for (int c = 0; c < width; c++) begin
            if (pick(4) == 0) begin
                s_valid = 1'b0;  // idle beat
                @(posedge aclk);
                #1;
            end
            s_valid = 1'b1;
            s_data  = row_pix[c];
            s_user  = row_tag[c];
            s_last  = (c == width - 1);
            target  = acc_cnt + 1;
            do begin
                @(posedge aclk);
                #1;
            end while (acc_cnt < target);
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
        while (rx_cnt < exp_total) begin
            @(posedge aclk);
            #1;
        end
    endtask

    always begin
        @(posedge aclk);
        stall_now = stall_row;
        #1;
        rdy_rng = lcg_step(rdy_rng);
        m_ready = stall_now ? (rdy_rng[31:16] % 16'd3 != 16'd0) : 1'b1;
    end

    always @(posedge aclk) begin
        if (!rst) begin
            if (!started) begin
                assert (!s_ready) else note_failure("s_ready high before the first start");
            end
            if (start) begin
                started = 1'b1;
            end
            if (s_valid && s_ready) begin
                acc_cnt++;
            end
            if (gap_active) begin
                if (!s_ready) begin
                    gap_cnt++;
                end else begin
                    gap_active = 1'b0;
                    if (gap_strict) begin
                        assert (gap_cnt == gap_half)
                            else report_mismatch("s_ready low cycles", 128'(gap_cnt),
                                                 128'(gap_half));
                    end else begin
                        assert (gap_cnt >= gap_half)
                            else note_failure("s_ready returned before the flush beats");
                    end
                end
            end
            if (s_valid && s_ready && s_last) begin
                gap_active = 1'b1;
                gap_cnt    = 0;
                gap_half   = cur_half;
                gap_strict = !stall_row;  // exact count only with m_ready held high
            end
            if (m_valid && m_ready) begin
                check_window();
            end
        end
    end

    assert property (@(posedge aclk) disable iff (rst)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_window) && $stable(m_mask)
                                   && $stable(m_user) && $stable(m_last)))
        else note_failure("outputs changed while m_ready was low");

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("timeout: run still busy after %0d cycles", cycle_cnt);
        $display("errors: %0d mismatch, %0d other", bad_values, bad_other);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        kernel_w_1 = '0;
        s_valid    = 1'b0;
        s_data     = '0;
        s_user     = '0;
        s_last     = 1'b0;
        m_ready    = 1'b1;
        repeat (4) @(posedge aclk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge aclk);  // s_ready must stay low here
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row();
        end
        repeat (10) @(posedge aclk);
        assert (exp_q.size() == 0) else note_failure("windows never arrived");
        $display("errors: %0d mismatch, %0d other", bad_values, bad_other);
        if (bad_values == 0 && bad_other == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== conv_pad.f ====
+incdir+source
source/conv_pad_pkg.sv
source/beat_if.sv
source/row_intake.sv
source/pad_filter.sv
source/window_emitter.sv
source/conv_pad_top.sv
dv/conv_pad_tb.sv

// ==== Makefile ====
TOP := conv_pad_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module conv_pad_top -f conv_pad.f
	verilator --lint-only -Wall --timing --top-module $(TOP) -f conv_pad.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f conv_pad.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
